//--- hci_mem_subsystem.f
verilog/hci_pkg.sv
verilog/hci_mem_if.sv
verilog/hci_router.sv
verilog/tcdm_bank.sv
verilog/hci_rdata_gather.sv
verilog/hci_mem_subsystem.sv
verif/hci_mem_subsystem_sva.sv
verif/tb_hci_mem_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  -f hci_mem_subsystem.f \
  --top-module tb_hci_mem_subsystem \
  -Mdir obj_dir -o sim_tb &&
./obj_dir/sim_tb || exit 1

//--- verif/hci_mem_subsystem_sva.sv
/* protocol checks on the wide port of the memory subsystem */
module hci_mem_subsystem_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic clear_i,
  input logic req_i,
  input logic wen_i,
  input logic gnt_i,
  input logic r_valid_i
);

  // a write grant never produces a response
  a_no_wr_resp: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (gnt_i && !wen_i) |=> !r_valid_i
  ) else $error("r_valid_o raised after a write grant");

  // no grant without a pending request
  a_gnt_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    gnt_i |-> req_i
  ) else $error("gnt_o high while req_i is low");

  // response path held quiet in reset
  a_rst_quiet: assert property (
    @(posedge clk_i) !rst_ni |-> !r_valid_i
  ) else $error("r_valid_o high during reset");

  // uncleared read returns one cycle after its grant
  a_rd_resp: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (gnt_i && wen_i && !clear_i) |=> (r_valid_i || clear_i)
  ) else $error("read grant not followed by r_valid_o");

endmodule

bind hci_mem_subsystem hci_mem_subsystem_sva i_hci_mem_subsystem_sva (
  .clk_i(clk_i),
  .rst_ni(rst_ni),
  .clear_i(clear_i),
  .req_i(req_i),
  .wen_i(wen_i),
  .gnt_i(gnt_o),
  .r_valid_i(r_valid_o)
);

//--- verif/tb_hci_mem_subsystem.sv
/* testbench for the memory subsystem: LFSR stimulus on the wide port,
   byte-level reference memory and a per-cycle response checker */
module tb_hci_mem_subsystem;
  import hci_pkg::*;

  localparam int unsigned DW = DEFAULT_DW;
  localparam int unsigned NB_BANKS = DEFAULT_NB_BANKS;
  localparam int unsigned BANK_WORDS = DEFAULT_BANK_WORDS;
  localparam int unsigned NB_LANES = DW / 32;
  localparam int unsigned MEM_BYTES = NB_BANKS * BANK_WORDS * 4;
  localparam int unsigned ADDR_BITS = $clog2(MEM_BYTES);
  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 4;
  // operation budget of each test phase
  localparam int N_FILL = NB_BANKS * BANK_WORDS / NB_LANES;
  localparam int N_MIX = 300;
  localparam int N_BURST = 200;
  localparam int N_DIRECTED = 40;
  localparam int N_OPS = N_FILL + N_MIX + N_BURST + N_DIRECTED;
  localparam int WATCHDOG_TIME = (N_OPS * 4 + RST_CYCLES) * CLK_PERIOD;
  localparam int GNT_WAIT_MAX = 8;

  logic clk_i;
  logic rst_ni;
  logic clear_i;
  logic req_i;
  logic wen_i;
  logic [ADDR_W-1:0] add_i;
  logic [DW/8-1:0] be_i;
  logic [DW-1:0] data_i;
  logic gnt_o;
  logic [DW-1:0] r_data_o;
  logic r_valid_o;

  // reference memory with one entry per byte
  logic [7:0] mem_model [MEM_BYTES];
  logic [31:0] lfsr_q = 32'h9f2e;
  // read accepted at the last edge and its expected data
  logic pend_rd = 1'b0;
  logic [DW-1:0] pend_data;

  hci_mem_subsystem #(
    .DW(DW),
    .NB_BANKS(NB_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) i_hci_mem_subsystem (
    .clk_i(clk_i),
    .rst_ni(rst_ni),
    .clear_i(clear_i),
    .req_i(req_i),
    .wen_i(wen_i),
    .add_i(add_i),
    .be_i(be_i),
    .data_i(data_i),
    .gnt_o(gnt_o),
    .r_data_o(r_data_o),
    .r_valid_o(r_valid_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // galois step with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // one LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [DW-1:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val = {val[DW-2:0], lfsr_q[0]};
    end
  endtask

  // byte address in the model of lane k, from the bank rotation rule
  function automatic int unsigned lane_base(input logic [ADDR_W-1:0] addr, input int k);
    int unsigned widx;
    int unsigned bank;
    int unsigned row;
    widx = addr >> 2;
    bank = widx % NB_BANKS + k;
    row = widx / NB_BANKS;
    // lane past the last bank moves to the next row
    if (bank >= NB_BANKS) begin
      bank = bank - NB_BANKS;
      row = row + 1;
    end
    row = row % BANK_WORDS;
    return (row * NB_BANKS + bank) * 4;
  endfunction

  // expected wide read word
  function automatic logic [DW-1:0] ref_read(input logic [ADDR_W-1:0] addr);
    logic [DW-1:0] res;
    int unsigned base;
    for (int k = 0; k < NB_LANES; k++) begin
      base = lane_base(addr, k);
      for (int i = 0; i < 4; i++) begin
        res[k*32 + i*8 +: 8] = mem_model[base + i];
      end
    end
    return res;
  endfunction

  task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [DW/8-1:0] be,
                             input logic [DW-1:0] data);
    int unsigned base;
    for (int k = 0; k < NB_LANES; k++) begin
      base = lane_base(addr, k);
      for (int i = 0; i < 4; i++) begin
        if (be[k*4 + i]) begin
          mem_model[base + i] = data[k*32 + i*8 +: 8];
        end
      end
    end
  endtask

  // fill word depends on the full word address of each lane
  function automatic logic [DW-1:0] fill_line(input int first_word);
    logic [DW-1:0] res;
    logic [15:0] wa;
    for (int k = 0; k < NB_LANES; k++) begin
      wa = 16'(first_word + k);
      res[k*32 +: 32] = {wa ^ 16'h3c5a, ~wa};
    end
    return res;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [DW-1:0] got,
                            input logic [DW-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // present one request at this edge and hold it until granted
  task automatic send(input logic wen, input logic [ADDR_W-1:0] addr,
                      input logic [DW/8-1:0] be, input logic [DW-1:0] data);
    int waits;
    waits = 0;
    req_i <= 1'b1;
    wen_i <= wen;
    add_i <= addr;
    be_i <= be;
    data_i <= data;
    @(negedge clk_i);
    while (!gnt_o) begin
      waits++;
      if (waits > GNT_WAIT_MAX) begin
        fail_run("request was never granted");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
  endtask

  task automatic idle(input int n);
    req_i <= 1'b0;
    repeat (n) @(posedge clk_i);
  endtask

  // read, then clear in the cycle its response is due
  task automatic read_and_clear(input logic [ADDR_W-1:0] addr);
    send(1'b1, addr, '0, '0);
    req_i <= 1'b0;
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
  endtask

  // compare process samples between edges
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      check_flag("r_valid_o", r_valid_o, 1'b0);
      pend_rd = 1'b0;
    end else begin
      // response of the read granted at the last edge is dropped by clear
      check_flag("r_valid_o", r_valid_o, pend_rd & ~clear_i);
      if (pend_rd && !clear_i) begin
        check_word("r_data_o", r_data_o, pend_data);
      end
      // banks always grant, so gnt follows req in the same cycle
      check_flag("gnt_o", gnt_o, req_i);
      pend_rd = 1'b0;
      if (gnt_o && wen_i) begin
        // clear at the grant edge also kills the flag
        pend_rd = ~clear_i;
        pend_data = ref_read(add_i);
      end else if (gnt_o) begin
        model_write(add_i, be_i, data_i);
      end
    end
  end

  initial begin
    #(WATCHDOG_TIME);
    fail_run("watchdog expired before the tests completed");
  end

  initial begin
    logic [DW-1:0] rnd_d;
    logic [DW-1:0] rnd_a;
    logic [DW-1:0] rnd_b;
    logic [DW-1:0] rnd_op;
    logic [ADDR_W-1:0] wrap_addr;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    clear_i = 1'b0;
    req_i = 1'b0;
    wen_i = 1'b0;
    add_i = '0;
    be_i = '0;
    data_i = '0;
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    // fill every bank word so later reads are defined
    for (int w = 0; w < N_FILL; w++) begin
      send(1'b0, ADDR_W'(w * DW / 8), '1, fill_line(w * NB_LANES));
    end
    idle(2);

    // full write and read back at bank 0
    rand_bits(DW, rnd_d);
    send(1'b0, '0, '1, rnd_d);
    send(1'b1, '0, '0, '0);
    idle(2);

    // start at the last bank so the upper lane wraps to bank 0 of the next row
    wrap_addr = ADDR_W'((5 * NB_BANKS + NB_BANKS - 1) * 4);
    rand_bits(DW, rnd_d);
    send(1'b0, wrap_addr, '1, rnd_d);
    send(1'b1, wrap_addr, '0, '0);
    send(1'b1, ADDR_W'(6 * NB_BANKS * 4), '0, '0);
    idle(2);

    // partial byte enables with a fixed pattern then a random one
    rand_bits(DW, rnd_d);
    send(1'b0, ADDR_W'(12 * 4), {(DW/16){2'b01}}, rnd_d);
    send(1'b1, ADDR_W'(12 * 4), '0, '0);
    rand_bits(ADDR_BITS, rnd_a);
    rand_bits(DW / 8, rnd_b);
    rand_bits(DW, rnd_d);
    send(1'b0, rnd_a[ADDR_W-1:0], rnd_b[DW/8-1:0], rnd_d);
    send(1'b1, rnd_a[ADDR_W-1:0], '0, '0);
    idle(2);

    // random reads and writes back to back
    for (int n = 0; n < N_MIX; n++) begin
      rand_bits(1, rnd_op);
      rand_bits(ADDR_BITS, rnd_a);
      rand_bits(DW / 8, rnd_b);
      rand_bits(DW, rnd_d);
      send(rnd_op[0], rnd_a[ADDR_W-1:0], rnd_b[DW/8-1:0], rnd_d);
    end
    idle(2);

    // a read every cycle
    for (int n = 0; n < N_BURST; n++) begin
      rand_bits(ADDR_BITS, rnd_a);
      send(1'b1, rnd_a[ADDR_W-1:0], '0, '0);
    end
    idle(2);

    // clear right after a read grant
    for (int n = 0; n < 3; n++) begin
      rand_bits(ADDR_BITS, rnd_a);
      read_and_clear(rnd_a[ADDR_W-1:0]);
    end
    idle(3);

    $display("Simulation passed");
    $finish;
  end

endmodule

//--- verilog/hci_mem_if.sv
/* word-level TCDM port between the router, the banks and the read gather */
interface hci_mem_if #(
  parameter int unsigned AW = 8
);
  import hci_pkg::*;

  // request, driven by the router
  logic req;
  // high for a read
  logic wen;
  // word index inside the bank
  logic [AW-1:0] add;
  be_t be;
  word_t data;

  // response, driven by the bank
  logic gnt;
  word_t r_data;
  logic r_valid;

  modport master (output req, wen, add, be, data, input gnt, r_data, r_valid);
  modport slave (input req, wen, add, be, data, output gnt, r_data, r_valid);
  // read-only view for the response path
  modport monitor (input gnt, r_data, r_valid);

endinterface

//--- verilog/hci_mem_subsystem.sv
/* TCDM-style memory subsystem: one wide port routed over word-interleaved
   SRAM banks with an in-order read gather */
module hci_mem_subsystem #(
  parameter int unsigned DW = hci_pkg::DEFAULT_DW,
  parameter int unsigned NB_BANKS = hci_pkg::DEFAULT_NB_BANKS,
  parameter int unsigned BANK_WORDS = hci_pkg::DEFAULT_BANK_WORDS
) (
  input logic clk_i,
  input logic rst_ni,
  input logic clear_i,
  // request side
  input logic req_i,
  input logic wen_i,
  input logic [hci_pkg::ADDR_W-1:0] add_i,
  input logic [DW/8-1:0] be_i,
  input logic [DW-1:0] data_i,
  output logic gnt_o,
  // response side
  output logic [DW-1:0] r_data_o,
  output logic r_valid_o
);
  import hci_pkg::*;

  // byte address decoded through the union
  hci_addr_u add_u;
  logic gnt;
  logic [$clog2(NB_BANKS)-1:0] bank_off;

  // one word port per bank
  hci_mem_if #(.AW($clog2(BANK_WORDS))) bank_if [NB_BANKS-1:0] ();

  assign add_u.flat = add_i;

  hci_router #(
    .DW(DW),
    .NB_BANKS(NB_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) i_hci_router (
    .req_i(req_i),
    .wen_i(wen_i),
    .add_i(add_u),
    .be_i(be_i),
    .data_i(data_i),
    .gnt_o(gnt),
    .banks(bank_if),
    .bank_off_o(bank_off)
  );

  for (genvar b = 0; b < NB_BANKS; b++) begin : g_bank
    tcdm_bank #(
      .BANK_WORDS(BANK_WORDS)
    ) i_tcdm_bank (
      .clk_i(clk_i),
      .rst_ni(rst_ni),
      .port(bank_if[b])
    );
  end

  hci_rdata_gather #(
    .DW(DW),
    .NB_BANKS(NB_BANKS)
  ) i_hci_rdata_gather (
    .clk_i(clk_i),
    .rst_ni(rst_ni),
    .clear_i(clear_i),
    .bank_off_i(bank_off),
    .gnt_i(gnt),
    .wen_i(wen_i),
    .banks(bank_if),
    .r_data_o(r_data_o),
    .r_valid_o(r_valid_o)
  );

  assign gnt_o = gnt;

endmodule

//--- verilog/hci_pkg.sv
/* hci shared definitions: default sizes of the wide port and the banks,
   lane geometry and the two views of a byte address */
package hci_pkg;

  // default wide port, two 32-bit lanes
  localparam int unsigned DEFAULT_DW = 64;
  // default word-interleaved bank count
  localparam int unsigned DEFAULT_NB_BANKS = 8;
  // default depth of one bank in words
  localparam int unsigned DEFAULT_BANK_WORDS = 256;
  // byte address width on the wide port
  localparam int unsigned ADDR_W = 32;

  // one lane is one bank word
  localparam int unsigned LANE_W = 32;
  localparam int unsigned LANE_BE_W = LANE_W / 8;

  // address split for the default bank count
  localparam int unsigned BYTE_OFF_W = 2;
  localparam int unsigned BANK_SEL_W = $clog2(DEFAULT_NB_BANKS);
  localparam int unsigned WORD_IDX_W = ADDR_W - BANK_SEL_W - BYTE_OFF_W;

  typedef logic [LANE_W-1:0] word_t;
  typedef logic [LANE_BE_W-1:0] be_t;

  // word-interleaved decode of a byte address
  // low bits pick the byte, middle bits the bank, upper bits the row
  typedef struct packed {
    logic [WORD_IDX_W-1:0] word_index;
    logic [BANK_SEL_W-1:0] bank;
    logic [BYTE_OFF_W-1:0] byte_off;
  } hci_addr_fields_t;

  // same word seen as a flat byte address or as its decoded fields
  typedef union packed {
    logic [ADDR_W-1:0] flat;
    hci_addr_fields_t fields;
  } hci_addr_u;

endpackage

//--- verilog/hci_rdata_gather.sv
/* read response gather: rotates bank read data back into lane order
   and passes r_valid only for a read accepted in the previous cycle */
module hci_rdata_gather #(
  parameter int unsigned DW = hci_pkg::DEFAULT_DW,
  parameter int unsigned NB_BANKS = hci_pkg::DEFAULT_NB_BANKS
) (
  input logic clk_i,
  input logic rst_ni,
  input logic clear_i,
  input logic [$clog2(NB_BANKS)-1:0] bank_off_i,
  input logic gnt_i,
  input logic wen_i,
  hci_mem_if.monitor banks [NB_BANKS-1:0],
  output logic [DW-1:0] r_data_o,
  output logic r_valid_o
);
  import hci_pkg::*;

  localparam int unsigned NB_IN_CHAN = DW / LANE_W;
  localparam int unsigned OFF_W = $clog2(NB_BANKS);

  // starting bank of the read in flight
  logic [OFF_W-1:0] off_q;
  // a read was accepted at the last edge
  logic rd_q;

  word_t [NB_BANKS-1:0] bank_rdata;
  logic [NB_BANKS-1:0] bank_rvalid;

  for (genvar b = 0; b < NB_BANKS; b++) begin : g_bank
    assign bank_rdata[b] = banks[b].r_data;
    assign bank_rvalid[b] = banks[b].r_valid;
  end

  // offset only matters for reads
  always_ff @(posedge clk_i) begin
    if (gnt_i & wen_i) begin
      off_q <= bank_off_i;
    end
  end

  // clear kills the read about to return
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_q <= 1'b0;
    end else if (clear_i) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= gnt_i & wen_i;
    end
  end

  // lane k comes from bank (offset+k) mod NB_BANKS
  for (genvar k = 0; k < NB_IN_CHAN; k++) begin : g_lane
    assign r_data_o[k*LANE_W +: LANE_W] = bank_rdata[off_q + OFF_W'(k)];
  end

  // lane-0 bank valid, filtered by the accepted-read flag
  // clear also drops a response landing in this cycle
  assign r_valid_o = bank_rvalid[off_q] & rd_q & ~clear_i;

endmodule

//--- verilog/hci_router.sv
/* wide-port router: splits a DW-bit request into 32-bit lanes and rotates
   them onto word-interleaved banks, returning the lane-0 grant */
module hci_router #(
  parameter int unsigned DW = hci_pkg::DEFAULT_DW,
  parameter int unsigned NB_BANKS = hci_pkg::DEFAULT_NB_BANKS,
  parameter int unsigned BANK_WORDS = hci_pkg::DEFAULT_BANK_WORDS
) (
  input logic req_i,
  input logic wen_i,
  input hci_pkg::hci_addr_u add_i,
  input logic [DW/8-1:0] be_i,
  input logic [DW-1:0] data_i,
  output logic gnt_o,
  hci_mem_if.master banks [NB_BANKS-1:0],
  output logic [$clog2(NB_BANKS)-1:0] bank_off_o
);
  import hci_pkg::*;

  localparam int unsigned NB_IN_CHAN = DW / LANE_W;
  localparam int unsigned OFF_W = $clog2(NB_BANKS);
  localparam int unsigned AW = $clog2(BANK_WORDS);

  // starting bank and row of the request
  logic [OFF_W-1:0] bank_off;
  logic [AW-1:0] row_base;

  // per-lane request fields
  logic [NB_IN_CHAN-1:0][OFF_W-1:0] lane_bank;
  logic [NB_IN_CHAN-1:0][AW-1:0] lane_add;
  be_t [NB_IN_CHAN-1:0] lane_be;
  word_t [NB_IN_CHAN-1:0] lane_data;

  // per-bank request fields after rotation
  logic [NB_BANKS-1:0] bank_req;
  logic [NB_BANKS-1:0][AW-1:0] bank_add;
  be_t [NB_BANKS-1:0] bank_be;
  word_t [NB_BANKS-1:0] bank_data;
  logic [NB_BANKS-1:0] bank_gnt;

  if (NB_IN_CHAN > NB_BANKS) begin : g_chk_lanes
    $error("wide port has more lanes than banks");
  end

  // struct view when the bank field matches the package split
  if (NB_BANKS == DEFAULT_NB_BANKS) begin : g_dec_fields
    assign bank_off = add_i.fields.bank;
    assign row_base = add_i.fields.word_index[AW-1:0];
  end else begin : g_dec_slice
    assign bank_off = add_i.flat[OFF_W+BYTE_OFF_W-1:BYTE_OFF_W];
    assign row_base = add_i.flat[OFF_W+BYTE_OFF_W +: AW];
  end

  for (genvar k = 0; k < NB_IN_CHAN; k++) begin : g_lane
    assign lane_be[k] = be_i[k*LANE_BE_W +: LANE_BE_W];
    assign lane_data[k] = data_i[k*LANE_W +: LANE_W];
    // bank index wraps modulo the bank count
    assign lane_bank[k] = bank_off + OFF_W'(k);
    // a lane past the last bank lands on the next row
    assign lane_add[k] = (int'(bank_off) + k >= int'(NB_BANKS)) ? row_base + AW'(1) : row_base;
  end

  // place each lane on its bank, idle banks see no request
  always_comb begin
    bank_req = '0;
    bank_add = '0;
    bank_be = '0;
    bank_data = '0;
    for (int k = 0; k < NB_IN_CHAN; k++) begin
      bank_req[lane_bank[k]] = req_i;
      bank_add[lane_bank[k]] = lane_add[k];
      bank_be[lane_bank[k]] = lane_be[k];
      bank_data[lane_bank[k]] = lane_data[k];
    end
  end

  for (genvar b = 0; b < NB_BANKS; b++) begin : g_bank
    assign banks[b].req = bank_req[b];
    assign banks[b].wen = wen_i;
    assign banks[b].add = bank_add[b];
    assign banks[b].be = bank_be[b];
    assign banks[b].data = bank_data[b];
    assign bank_gnt[b] = banks[b].gnt;
  end

  // all lanes move together, so lane 0 speaks for the request
  assign gnt_o = req_i & bank_gnt[bank_off];
  assign bank_off_o = bank_off;

endmodule

//--- verilog/tcdm_bank.sv
/* single-port word-wide SRAM bank with byte enables,
   always grants and returns read data one cycle later */
module tcdm_bank #(
  parameter int unsigned BANK_WORDS = hci_pkg::DEFAULT_BANK_WORDS
) (
  input logic clk_i,
  input logic rst_ni,
  hci_mem_if.slave port
);
  import hci_pkg::*;

  // storage array
  word_t mem_q [BANK_WORDS];
  // read data register
  word_t r_data_q;
  logic r_valid_q;

  // no other initiator, so every request is granted
  assign port.gnt = port.req;

  // write enabled bytes, or capture the addressed word for a read
  always_ff @(posedge clk_i) begin
    if (port.req) begin
      if (port.wen) begin
        r_data_q <= mem_q[port.add];
      end else begin
        for (int i = 0; i < LANE_BE_W; i++) begin
          if (port.be[i]) begin
            mem_q[port.add][i*8 +: 8] <= port.data[i*8 +: 8];
          end
        end
      end
    end
  end

  // valid follows a granted read by one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= port.req & port.wen;
    end
  end

  assign port.r_data = r_data_q;
  assign port.r_valid = r_valid_q;

endmodule
